//--- tb.f
rtl/radarPkg.sv
rtl/servoPwm.sv
rtl/echoRanger.sv
rtl/sweepSequencer.sv
rtl/alarmBeeper.sv
rtl/distanceDisplay.sv
rtl/radarTop.sv
verif/radarTb.sv

//--- run.sh
#!/bin/sh
# build and run the radar testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module radarTb -Mdir obj_dir -o radarSim -f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/radarSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- verif/radarTb.sv
`timescale 1ns/1ns

module radarTb;
	import radarPkg::*;

	localparam int stepTicks = 2000;
	localparam int pwmBits = 10;
	localparam int ticksPerCm = 8;
	localparam int triggerTicks = 20;
	localparam int beatTicks = 300;
	localparam int toneTicks = 10;
	localparam int sweepsToRun = 6;

	logic clk;
	logic reset;
	logic echo;
	logic trigger;
	logic servoPulse;
	logic speaker;
	sweepStateT sweepStep;
	servoAngleT servoAngle;
	alarmLevelT alarmLevel;
	logic [6:0] digitOnes;
	logic [6:0] digitTens;
	logic [6:0] digitHundreds;
	logic [6:0] digitSpare;

	int mismatchCount = 0;
	int failureCount = 0;
	bit timedOut = 0;
	logic [15:0] lfsr = 16'd74;
	int windowCm = 0;
	int stopCm [4];
	int sweepsDone = 0;
	bit [2:0] levelsSeen = '0;
	int servoChecks = 0;
	int beatChecks = 0;

	sweepStateT prevStep;
	sweepStateT lastStep;
	int stepCycles;
	bit trigPrev;
	int trigRun;
	int sinceRise;
	bit riseSeen;
	int showDelay;
	int capturedCm;
	int shownCm;
	bit shownValid;
	alarmLevelT expectedAlarm;
	logic [6:0] expOnes;
	logic [6:0] expTens;
	logic [6:0] expHundreds;
	servoAngleT prevAngle;
	int angleStable;
	int pulseRun;
	alarmLevelT prevLevel;
	int levelStable;
	bit spkPrev;
	int lowLen;
	int highLen;
	int burstLen;
	bit inBurst;
	bit fallSeen;

	radarTop #(
		.stepTicks(stepTicks),
		.pwmBits(pwmBits),
		.ticksPerCm(ticksPerCm),
		.triggerTicks(triggerTicks),
		.beatTicks(beatTicks),
		.toneTicks(toneTicks)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.echo(echo),
		.trigger(trigger),
		.servoPulse(servoPulse),
		.speaker(speaker),
		.sweepStep(sweepStep),
		.servoAngle(servoAngle),
		.alarmLevel(alarmLevel),
		.digitOnes(digitOnes),
		.digitTens(digitTens),
		.digitHundreds(digitHundreds),
		.digitSpare(digitSpare)
	);

	task automatic reportMismatch(input string name, input int got, input int expected);
		mismatchCount++;
		$display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
	endtask

	task automatic reportFailure(input string what);
		failureCount++;
		$display("%s at %0t", what, $time);
	endtask

	// 7-segment patterns of the board, active low, segment g in the top bit
	function automatic logic [6:0] segmentsFor(input int digit);
		case (digit)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			default: return 7'b0011000;
		endcase
	endfunction

	// high cycles in one 1024-cycle servo period at each stop
	function automatic int highCyclesFor(input servoAngleT angle);
		case (angle)
			angle0: return 633;
			angle180: return 242;
			default: return 438;
		endcase
	endfunction

	function automatic int beatLengthFor(input alarmLevelT level);
		case (level)
			alarmNear: return beatTicks;
			alarmMid: return 2 * beatTicks;
			default: return 4 * beatTicks;
		endcase
	endfunction

	// three states per stop, alarmDecide stays at the last stop
	function automatic servoAngleT angleFor(input sweepStateT step);
		case (int'(step) / 3)
			0: return angle0;
			2: return angle180;
			default: return angle90;
		endcase
	endfunction

	function automatic sweepStateT nextStep(input sweepStateT step);
		if (step == alarmDecide) begin
			return aimRight;
		end
		return sweepStateT'(int'(step) + 1);
	endfunction

	// near at any stop beats mid at any stop
	function automatic alarmLevelT expectedLevel();
		alarmLevelT level;
		int i;
		level = alarmClear;
		for (i = 0; i < 4; i++) begin
			if (stopCm[i] != 0 && stopCm[i] <= 10) begin
				level = alarmNear;
			end else if (stopCm[i] > 10 && stopCm[i] <= 30 && level == alarmClear) begin
				level = alarmMid;
			end
		end
		return level;
	endfunction

	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	task automatic drawBits(input int count, output int value);
		logic feedback;
		int i;
		value = 0;
		for (i = 0; i < count; i++) begin
			feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], feedback};
			value = (value << 1) | int'(feedback);
		end
	endtask

	// window n runs during state n mod 13, so aim windows feed the samples
	task automatic pickDistance(input int windowIndex, output int cm);
		int sweep;
		int slot;
		int cls;
		int value;
		sweep = windowIndex / 13;
		slot = windowIndex % 13;
		drawBits(2, cls);
		case (sweep % 3)
			0: begin
				if (cls < 2) cls = cls + 2;
			end
			1: begin
				if (cls == 0 || slot == 3) cls = 1;
			end
			default: begin
				if (slot == 0) cls = 0;
			end
		endcase
		case (cls)
			0: begin
				drawBits(4, value);
				cm = 1 + value % 10;
			end
			1: begin
				drawBits(5, value);
				cm = 11 + value % 20;
			end
			2: begin
				drawBits(8, value);
				cm = 31 + value % 169;
			end
			default: begin
				// no echo at all, or beyond the range limit
				drawBits(5, value);
				cm = (value < 4) ? 0 : 196 + value;
			end
		endcase
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// one echo burst per window, started after the trigger falls
	initial begin : echoDriver
		int windowIndex;
		int cm;
		int waited;
		echo = 1'b0;
		windowIndex = 0;
		while (!timedOut) begin
			waited = 0;
			@(posedge clk);
			#1;
			while (!trigger && waited < 2100) begin
				@(posedge clk);
				#1;
				waited++;
			end
			if (!trigger) begin
				reportFailure("trigger did not rise within 2100 cycles");
				timedOut = 1;
			end else begin
				waited = 0;
				while (trigger && waited < 40) begin
					@(posedge clk);
					#1;
					waited++;
				end
				if (trigger) begin
					reportFailure("trigger stayed high for 40 cycles");
					timedOut = 1;
				end else begin
					pickDistance(windowIndex, cm);
					if (cm > 0) begin
						echo = 1'b1;
						repeat (cm * ticksPerCm) @(posedge clk);
						#1;
						echo = 1'b0;
					end
					windowCm = (cm >= 200) ? 0 : cm;
					windowIndex++;
				end
			end
		end
	end

	// sweep order, state length and servo angle
	always @(negedge clk) begin
		if (reset) begin
			prevStep = aimRight;
			stepCycles = 0;
		end else begin
			if (sweepStep != prevStep) begin
				assert (sweepStep == nextStep(prevStep))
					else reportMismatch("sweepStep", int'(sweepStep), int'(nextStep(prevStep)));
				assert (stepCycles == stepTicks)
					else reportFailure($sformatf("state %0d lasted %0d cycles",
						int'(prevStep), stepCycles));
				stepCycles = 0;
			end
			stepCycles++;
			prevStep = sweepStep;
			assert (servoAngle == angleFor(sweepStep))
				else reportMismatch("servoAngle", int'(servoAngle), int'(angleFor(sweepStep)));
		end
	end

	always @(negedge clk) begin
		if (reset) begin
			trigPrev = 0;
			trigRun = 0;
			sinceRise = 0;
			riseSeen = 0;
		end else begin
			sinceRise++;
			if (trigger) begin
				if (!trigPrev) begin
					if (riseSeen) begin
						assert (sinceRise == stepTicks)
							else reportFailure($sformatf("trigger rose %0d cycles apart", sinceRise));
					end
					riseSeen = 1;
					sinceRise = 0;
				end
				trigRun++;
			end else if (trigPrev) begin
				assert (trigRun == triggerTicks)
					else reportFailure($sformatf("trigger was high for %0d cycles", trigRun));
				trigRun = 0;
			end
			trigPrev = trigger;
		end
	end

	// digits follow each sample two cycles later, alarm follows each sweep
	always @(negedge clk) begin
		if (reset) begin
			showDelay = 0;
			shownValid = 0;
			expectedAlarm = alarmClear;
			lastStep = aimRight;
		end else begin
			if (showDelay > 0) begin
				showDelay--;
				if (showDelay == 0) begin
					shownCm = capturedCm;
					shownValid = 1;
				end
			end
			if (sweepStep != lastStep) begin
				case (sweepStep)
					sampleRight, sampleCenterA, sampleLeft, sampleCenterB: begin
						capturedCm = windowCm;
						stopCm[int'(sweepStep) / 3] = windowCm;
						showDelay = 2;
					end
					alarmDecide: begin
						expectedAlarm = expectedLevel();
						levelsSeen[int'(expectedAlarm)] = 1'b1;
						sweepsDone++;
					end
					default: begin
					end
				endcase
			end
			lastStep = sweepStep;
			if (shownValid) begin
				expOnes = segmentsFor(shownCm % 10);
				expTens = segmentsFor(shownCm / 10 % 10);
				expHundreds = segmentsFor(shownCm / 100);
			end else begin
				expOnes = 7'b1111111;
				expTens = 7'b1111111;
				expHundreds = 7'b1111111;
			end
			assert (digitOnes == expOnes)
				else reportMismatch("digitOnes", int'(digitOnes), int'(expOnes));
			assert (digitTens == expTens)
				else reportMismatch("digitTens", int'(digitTens), int'(expTens));
			assert (digitHundreds == expHundreds)
				else reportMismatch("digitHundreds", int'(digitHundreds), int'(expHundreds));
			assert (digitSpare == 7'b1111111)
				else reportMismatch("digitSpare", int'(digitSpare), 'h7f);
			assert (alarmLevel == expectedAlarm)
				else reportMismatch("alarmLevel", int'(alarmLevel), int'(expectedAlarm));
		end
	end

	// high run per servo period, once the angle has held a full period
	always @(negedge clk) begin
		if (reset) begin
			prevAngle = angle0;
			angleStable = 0;
			pulseRun = 0;
		end else begin
			angleStable = (servoAngle == prevAngle) ? angleStable + 1 : 0;
			prevAngle = servoAngle;
			if (servoPulse) begin
				pulseRun++;
			end else if (pulseRun > 0) begin
				if (angleStable >= (1 << pwmBits)) begin
					assert (pulseRun == highCyclesFor(servoAngle))
						else reportMismatch("servoPulse high cycles", pulseRun,
							highCyclesFor(servoAngle));
					servoChecks++;
				end
				pulseRun = 0;
			end
		end
	end

	// gaps and bursts against the beat length, 10-cycle toggles inside a burst
	always @(negedge clk) begin
		if (reset) begin
			prevLevel = alarmClear;
			levelStable = 0;
			spkPrev = 0;
			lowLen = 0;
			highLen = 0;
			burstLen = 0;
			inBurst = 0;
			fallSeen = 0;
		end else begin
			levelStable = (alarmLevel == prevLevel) ? levelStable + 1 : 0;
			prevLevel = alarmLevel;
			if (inBurst) burstLen++;
			if (speaker) begin
				if (!spkPrev) begin
					if (inBurst) begin
						assert (lowLen == toneTicks)
							else reportFailure($sformatf("speaker low for %0d cycles in a burst", lowLen));
					end else begin
						if (fallSeen && levelStable > lowLen + 40) begin
							assert (lowLen >= beatLengthFor(alarmLevel) - 2 * toneTicks &&
								lowLen <= beatLengthFor(alarmLevel) + 2 * toneTicks)
								else reportFailure($sformatf("silent gap of %0d cycles", lowLen));
							beatChecks++;
						end
						inBurst = 1;
						burstLen = 1;
					end
					lowLen = 0;
				end
				highLen++;
			end else begin
				if (spkPrev) begin
					assert (highLen == toneTicks)
						else reportFailure($sformatf("speaker high for %0d cycles", highLen));
					highLen = 0;
				end
				lowLen++;
				if (inBurst && lowLen == toneTicks + 1) begin
					inBurst = 0;
					fallSeen = 1;
					if (levelStable > burstLen + 40) begin
						assert (burstLen - lowLen >= beatLengthFor(alarmLevel) - 2 * toneTicks &&
							burstLen - lowLen <= beatLengthFor(alarmLevel) + 2 * toneTicks)
							else reportFailure($sformatf("tone burst of %0d cycles", burstLen - lowLen));
						beatChecks++;
					end
				end
			end
			spkPrev = speaker;
		end
	end

	initial begin
		int waited;
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		waited = 0;
		while (sweepsDone < sweepsToRun && !timedOut && waited < 200000) begin
			@(posedge clk);
			waited++;
		end
		if (sweepsDone < sweepsToRun && !timedOut) begin
			reportFailure("timeout waiting for six completed sweeps");
		end
		if (servoChecks == 0) reportFailure("no servo period was checked");
		if (beatChecks == 0) reportFailure("no beeper beat was checked");
		if (levelsSeen != 3'b111) reportFailure("not every alarm level was reached");
		$display("%0d mismatches, %0d other failures", mismatchCount, failureCount);
		if (mismatchCount == 0 && failureCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- rtl/radarTop.sv
`timescale 1ns/1ns

module radarTop #(
	parameter int stepTicks = 12500000,
	parameter int pwmBits = 17,
	parameter int ticksPerCm = 2942,
	parameter int triggerTicks = 500,
	parameter int beatTicks = 6250000,
	parameter int toneTicks = 23889
) (
	input logic clk,
	input logic reset,
	input logic echo,
	output logic trigger,
	output logic servoPulse,
	output logic speaker,
	output radarPkg::sweepStateT sweepStep,
	output radarPkg::servoAngleT servoAngle,
	output radarPkg::alarmLevelT alarmLevel,
	output logic [6:0] digitOnes,
	output logic [6:0] digitTens,
	output logic [6:0] digitHundreds,
	output logic [6:0] digitSpare
);
	import radarPkg::*;

	logic sample;
	distanceT distance;
	logic distanceValid;

	sweepSequencer #(
		.stepTicks(stepTicks)
	) sequencer_i (
		.clk(clk),
		.reset(reset),
		.distance(distance),
		.sample(sample),
		.servoAngle(servoAngle),
		.state(sweepStep),
		.alarmLevel(alarmLevel)
	);

	servoPwm #(
		.pwmBits(pwmBits)
	) servo_i (
		.clk(clk),
		.reset(reset),
		.servoAngle(servoAngle),
		.pulse(servoPulse)
	);

	// ranger window runs in step with the sequencer
	echoRanger #(
		.stepTicks(stepTicks),
		.ticksPerCm(ticksPerCm),
		.triggerTicks(triggerTicks)
	) ranger_i (
		.clk(clk),
		.reset(reset),
		.echo(echo),
		.sample(sample),
		.trigger(trigger),
		.distance(distance),
		.distanceValid(distanceValid)
	);

	alarmBeeper #(
		.beatTicks(beatTicks),
		.toneTicks(toneTicks)
	) beeper_i (
		.clk(clk),
		.reset(reset),
		.alarmLevel(alarmLevel),
		.speaker(speaker)
	);

	distanceDisplay display_i (
		.clk(clk),
		.reset(reset),
		.distanceValid(distanceValid),
		.distance(distance),
		.digitOnes(digitOnes),
		.digitTens(digitTens),
		.digitHundreds(digitHundreds),
		.digitSpare(digitSpare)
	);

endmodule

//--- rtl/distanceDisplay.sv
`timescale 1ns/1ns

module distanceDisplay (
	input logic clk,
	input logic reset,
	input logic distanceValid,
	input radarPkg::distanceT distance,
	output logic [6:0] digitOnes,
	output logic [6:0] digitTens,
	output logic [6:0] digitHundreds,
	output logic [6:0] digitSpare
);
	import radarPkg::*;

	logic [3:0] onesValue;
	logic [3:0] tensValue;
	logic [3:0] hundredsValue;

	// decimal split, an 8-bit distance never goes past 2 hundreds
	assign hundredsValue = 4'(distance / 8'd100);
	assign tensValue = 4'((distance / 8'd10) % 8'd10);
	assign onesValue = 4'(distance % 8'd10);

	always_ff @(posedge clk) begin
		if (reset) begin
			digitOnes <= segBlank;
			digitTens <= segBlank;
			digitHundreds <= segBlank;
		end else if (distanceValid) begin
			digitOnes <= segDigits[onesValue];
			digitTens <= segDigits[tensValue];
			digitHundreds <= segDigits[hundredsValue];
		end
	end

	// fourth digit stays dark
	assign digitSpare = segBlank;

endmodule

//--- rtl/alarmBeeper.sv
`timescale 1ns/1ns

module alarmBeeper #(
	parameter int beatTicks = 6250000,
	parameter int toneTicks = 23889
) (
	input logic clk,
	input logic reset,
	input radarPkg::alarmLevelT alarmLevel,
	output logic speaker
);
	import radarPkg::*;

	localparam int beatW = $clog2(4 * beatTicks);
	localparam int toneW = $clog2(toneTicks + 1);

	logic [beatW-1:0] beatCount;
	logic [beatW-1:0] beatLast;
	logic tonePhase;
	logic [toneW-1:0] toneCount;

	// closer objects give a faster cadence
	always_comb begin
		case (alarmLevel)
			alarmNear: beatLast = beatW'(beatTicks - 1);
			alarmMid: beatLast = beatW'(2 * beatTicks - 1);
			default: beatLast = beatW'(4 * beatTicks - 1);
		endcase
	end

	// beat counter runs down, level is picked up when a new beat begins
	always_ff @(posedge clk) begin
		if (reset) begin
			beatCount <= beatW'(4 * beatTicks - 1);
			tonePhase <= 1'b0;
		end else if (beatCount == '0) begin
			beatCount <= beatLast;
			tonePhase <= !tonePhase;
		end else begin
			beatCount <= beatCount - 1'b1;
		end
	end

	// square wave starts low at every beat
	always_ff @(posedge clk) begin
		if (reset) begin
			toneCount <= '0;
			speaker <= 1'b0;
		end else if (beatCount == '0 || !tonePhase) begin
			toneCount <= '0;
			speaker <= 1'b0;
		end else if (toneCount == toneW'(toneTicks - 1)) begin
			toneCount <= '0;
			speaker <= !speaker;
		end else begin
			toneCount <= toneCount + 1'b1;
		end
	end

	silentBeatQuiet: assert property (@(posedge clk) disable iff (reset)
		!tonePhase |-> !speaker);

endmodule

//--- rtl/sweepSequencer.sv
`timescale 1ns/1ns

module sweepSequencer #(
	parameter int stepTicks = 12500000
) (
	input logic clk,
	input logic reset,
	input radarPkg::distanceT distance,
	output logic sample,
	output radarPkg::servoAngleT servoAngle,
	output radarPkg::sweepStateT state,
	output radarPkg::alarmLevelT alarmLevel
);
	import radarPkg::*;

	localparam int stepW = $clog2(stepTicks);

	logic [stepW-1:0] stepCount;
	logic stepEnd;
	sweepStateT nextState;
	logic [1:0] stopIndex;
	logic isNear;
	logic isMid;
	logic [3:0] nearFlags;
	logic [3:0] midFlags;

	assign stepEnd = stepCount == stepW'(stepTicks - 1);

	always_ff @(posedge clk) begin
		if (reset || stepEnd) begin
			stepCount <= '0;
		end else begin
			stepCount <= stepCount + 1'b1;
		end
	end

	always_comb begin
		if (state == alarmDecide) begin
			nextState = aimRight;
		end else begin
			nextState = sweepStateT'(state + 4'd1);
		end
	end

	// which stop the upcoming record state belongs to
	always_comb begin
		case (nextState)
			recordCenterA: stopIndex = 2'd1;
			recordLeft: stopIndex = 2'd2;
			recordCenterB: stopIndex = 2'd3;
			default: stopIndex = 2'd0;
		endcase
	end

	// zero means nothing came back
	assign isNear = distance != '0 && distance <= nearLimitCm;
	assign isMid = distance > nearLimitCm && distance <= midLimitCm;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= aimRight;
			sample <= 1'b0;
			nearFlags <= '0;
			midFlags <= '0;
			alarmLevel <= alarmClear;
		end else begin
			sample <= 1'b0;
			if (stepEnd) begin
				state <= nextState;
				case (nextState)
					sampleRight, sampleCenterA, sampleLeft, sampleCenterB: begin
						sample <= 1'b1;
					end
					recordRight, recordCenterA, recordLeft, recordCenterB: begin
						nearFlags[stopIndex] <= isNear;
						midFlags[stopIndex] <= isMid;
					end
					alarmDecide: begin
						// any near stop wins over any mid stop
						if (|nearFlags) begin
							alarmLevel <= alarmNear;
						end else if (|midFlags) begin
							alarmLevel <= alarmMid;
						end else begin
							alarmLevel <= alarmClear;
						end
						nearFlags <= '0;
						midFlags <= '0;
					end
					default: begin
					end
				endcase
			end
		end
	end

	always_comb begin
		case (state)
			aimRight, sampleRight, recordRight: servoAngle = angle0;
			aimLeft, sampleLeft, recordLeft: servoAngle = angle180;
			default: servoAngle = angle90;
		endcase
	end

	sampleOneCycle: assert property (@(posedge clk) disable iff (reset)
		sample |=> !sample);

	stateLegal: assert property (@(posedge clk) disable iff (reset)
		state <= alarmDecide);

endmodule

//--- rtl/echoRanger.sv
`timescale 1ns/1ns

module echoRanger #(
	parameter int stepTicks = 12500000,
	parameter int ticksPerCm = 2942,
	parameter int triggerTicks = 500
) (
	input logic clk,
	input logic reset,
	input logic echo,
	input logic sample,
	output logic trigger,
	output radarPkg::distanceT distance,
	output logic distanceValid
);
	import radarPkg::*;

	localparam int windowW = $clog2(stepTicks);
	localparam int subW = $clog2(ticksPerCm + 1);

	logic [windowW-1:0] windowCount;
	logic windowEnd;
	logic [subW-1:0] subCount;
	distanceT cmCount;
	distanceT windowResult;

	assign windowEnd = windowCount == windowW'(stepTicks - 1);

	// trigger is registered from the window count, one cycle behind it
	always_ff @(posedge clk) begin
		if (reset) begin
			windowCount <= '0;
			trigger <= 1'b0;
		end else begin
			windowCount <= windowEnd ? '0 : windowCount + 1'b1;
			trigger <= windowCount < windowW'(triggerTicks);
		end
	end

	// echo width in centimetres, held at the range limit
	always_ff @(posedge clk) begin
		if (reset || windowEnd) begin
			subCount <= '0;
			cmCount <= '0;
		end else if (echo && cmCount != maxRangeCm) begin
			if (subCount == subW'(ticksPerCm - 1)) begin
				subCount <= '0;
				cmCount <= cmCount + 1'b1;
			end else begin
				subCount <= subCount + 1'b1;
			end
		end
	end

	// out of range reads as no object
	always_ff @(posedge clk) begin
		if (windowEnd) begin
			windowResult <= (cmCount >= maxRangeCm) ? '0 : cmCount;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			distance <= '0;
			distanceValid <= 1'b0;
		end else begin
			distanceValid <= sample;
			if (sample) begin
				distance <= windowResult;
			end
		end
	end

	triggerInWindow: assert property (@(posedge clk) disable iff (reset)
		trigger |-> windowCount != '0 && windowCount <= windowW'(triggerTicks));

endmodule

//--- rtl/servoPwm.sv
`timescale 1ns/1ns

module servoPwm #(
	parameter int pwmBits = 17
) (
	input logic clk,
	input logic reset,
	input radarPkg::servoAngleT servoAngle,
	output logic pulse
);
	import radarPkg::*;

	logic [pwmBits-1:0] counter;
	logic [16:0] fullThreshold;
	logic [pwmBits-1:0] threshold;

	always_comb begin
		case (servoAngle)
			angle0: fullThreshold = servoThreshold0;
			angle180: fullThreshold = servoThreshold180;
			default: fullThreshold = servoThreshold90;
		endcase
	end

	// scale the reference down to the counter width
	assign threshold = pwmBits'(fullThreshold >> (17 - pwmBits));

	always_ff @(posedge clk) begin
		if (reset) begin
			counter <= '0;
			pulse <= 1'b0;
		end else begin
			counter <= counter + 1'b1;
			pulse <= counter > threshold;
		end
	end

endmodule

//--- rtl/radarPkg.sv
package radarPkg;

	// servo stops, right to left
	typedef enum logic [1:0] {
		angle0,
		angle90,
		angle180
	} servoAngleT;

	// aim, sample and record at each of the four stops, then decide
	typedef enum logic [3:0] {
		aimRight,
		sampleRight,
		recordRight,
		aimCenterA,
		sampleCenterA,
		recordCenterA,
		aimLeft,
		sampleLeft,
		recordLeft,
		aimCenterB,
		sampleCenterB,
		recordCenterB,
		alarmDecide
	} sweepStateT;

	typedef enum logic [1:0] {
		alarmClear,
		alarmMid,
		alarmNear
	} alarmLevelT;

	typedef logic [7:0] distanceT;

	// servo reference thresholds at full 17-bit resolution
	localparam logic [16:0] servoThreshold0 = 17'd50000;
	localparam logic [16:0] servoThreshold90 = 17'd75000;
	localparam logic [16:0] servoThreshold180 = 17'd100000;

	localparam distanceT nearLimitCm = 8'd10;
	localparam distanceT midLimitCm = 8'd30;
	localparam distanceT maxRangeCm = 8'd200;

	// active low, segment g in the top bit
	localparam logic [6:0] segDigits [0:9] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
		7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0011000
	};
	localparam logic [6:0] segBlank = 7'b1111111;

endpackage
